// ==== hw/aos_demo_app.sv ====
/*
 * Demo application slot
 *   registers 0..2  read/write scratch
 *   register 3      read-only count of accepted writes
 */
`timescale 1ns/1ps
`include "aos_params.svh"

module aos_demo_app (
	input  logic              global_clk,
	input  logic              arst_n,
	input  aos_pkg::sr_req_t  req,
	output aos_pkg::sr_resp_t resp
);

	localparam logic [`AOS_DATA_W-1:0] COUNT_ONE = 1;

	logic [`AOS_REG_SEL_W-1:0] reg_sel;
	logic                      wr_en;
	logic                      rd_en;
	logic [`AOS_DATA_W-1:0]    scratch_q [3];
	logic [`AOS_DATA_W-1:0]    wr_count_q;
	logic [`AOS_DATA_W-1:0]    rd_data;
	logic                      rd_valid_q;
	logic [`AOS_DATA_W-1:0]    rd_data_q;

	assign reg_sel = req.addr[`AOS_REG_SEL_LSB +: `AOS_REG_SEL_W];
	assign wr_en   = req.valid && (req.op == aos_pkg::SR_WRITE);
	assign rd_en   = req.valid && (req.op == aos_pkg::SR_READ);

	always_comb begin
		case (reg_sel)
			2'd0:    rd_data = scratch_q[0];
			2'd1:    rd_data = scratch_q[1];
			2'd2:    rd_data = scratch_q[2];
			default: rd_data = wr_count_q;
		endcase
	end

	// Register 3 ignores the data but the write still counts
	always_ff @(posedge global_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 3; i++) begin
				scratch_q[i] <= '0;
			end
			wr_count_q <= '0;
		end else if (wr_en) begin
			case (reg_sel)
				2'd0:    scratch_q[0] <= req.data;
				2'd1:    scratch_q[1] <= req.data;
				2'd2:    scratch_q[2] <= req.data;
				default: ;
			endcase
			wr_count_q <= wr_count_q + COUNT_ONE;
		end
	end

	always_ff @(posedge global_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= rd_en;
		end
	end

	always_ff @(posedge global_clk) begin
		if (rd_en) begin
			rd_data_q <= rd_data;
		end
	end

	assign resp.valid = rd_valid_q;
	assign resp.data  = rd_data_q;

endmodule

// ==== hw/aos_params.svh ====
/*
 * Shared constants for the soft-register shell
 *   slot count, bus widths, address field positions,
 *   pipe depths and the value returned by dead reads
 */
`ifndef AOS_PARAMS_SVH
`define AOS_PARAMS_SVH

`define AOS_NUM_APPS          4
`define AOS_ADDR_W            32
`define AOS_DATA_W            64

// Address decode: slot in bits 9..8, 8-byte register in bits 4..3
`define AOS_APP_SEL_LSB       8
`define AOS_APP_SEL_W         2
`define AOS_REG_SEL_LSB       3
`define AOS_REG_SEL_W         2

`define AOS_HOST_PIPE_STAGES  2
`define AOS_APP_PIPE_STAGES   2

`define AOS_DEAD_DATA         64'hdead_beef_dead_beef

`endif

// ==== hw/aos_pkg.sv ====
/*
 * Types for the soft-register shell
 *   sr_op_e     request opcode
 *   sr_req_t    request bus (valid, op, addr, data)
 *   sr_resp_t   response bus (valid, data)
 *   rt_state_e  router read-tracking states
 */
`include "aos_params.svh"

package aos_pkg;

	typedef enum logic {
		SR_READ  = 1'b0,
		SR_WRITE = 1'b1
	} sr_op_e;

	// 98 bits in all
	typedef struct packed {
		logic                   valid;
		sr_op_e                 op;
		logic [`AOS_ADDR_W-1:0] addr;
		logic [`AOS_DATA_W-1:0] data;
	} sr_req_t;

	// 65 bits in all
	typedef struct packed {
		logic                   valid;
		logic [`AOS_DATA_W-1:0] data;
	} sr_resp_t;

	typedef enum logic {
		RT_IDLE      = 1'b0,
		RT_WAIT_READ = 1'b1
	} rt_state_e;

endpackage

// ==== hw/aos_rst_sync.sv ====
/*
 * Reset synchronizer
 *   asserts asynchronously, releases after two clock edges
 */
`timescale 1ns/1ps

module aos_rst_sync (
	input  logic global_clk,
	input  logic arst_n,
	output logic rst_sync_n
);

	logic [1:0] sync_q;

	// Shift ones in after release
	always_ff @(posedge global_clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
		end
	end

	assign rst_sync_n = sync_q[1];

endmodule

// ==== hw/aos_shell_top.sv ====
/*
 * Shell top level
 *   reset synchronizer, host-side request and response pipes,
 *   router, and per slot a request pipe, response pipe and demo app
 */
`timescale 1ns/1ps
`include "aos_params.svh"

module aos_shell_top (
	input  logic                     global_clk,
	input  logic                     arst_n,
	input  aos_pkg::sr_req_t         host_req,
	input  logic [`AOS_NUM_APPS-1:0] app_enable,
	output aos_pkg::sr_resp_t        host_resp,
	output logic                     busy
);

	logic              rst_sync_n;

	aos_pkg::sr_req_t  rt_host_req;
	aos_pkg::sr_resp_t rt_host_resp;

	// Router side and app side of each slot pipe
	aos_pkg::sr_req_t  rt_app_req  [`AOS_NUM_APPS];
	aos_pkg::sr_resp_t rt_app_resp [`AOS_NUM_APPS];
	aos_pkg::sr_req_t  app_req     [`AOS_NUM_APPS];
	aos_pkg::sr_resp_t app_resp    [`AOS_NUM_APPS];

	aos_rst_sync rst_sync_i (
		.global_clk (global_clk),
		.arst_n     (arst_n),
		.rst_sync_n (rst_sync_n)
	);

	// ------------------------------------------------------------------
	// Host side buffering
	// ------------------------------------------------------------------
	aos_sr_pipe #(
		.STAGES (`AOS_HOST_PIPE_STAGES),
		.T      (aos_pkg::sr_req_t)
	) host_req_pipe_i (
		.global_clk (global_clk),
		.arst_n     (rst_sync_n),
		.in_bus     (host_req),
		.out_bus    (rt_host_req)
	);

	aos_sr_pipe #(
		.STAGES (`AOS_HOST_PIPE_STAGES),
		.T      (aos_pkg::sr_resp_t)
	) host_resp_pipe_i (
		.global_clk (global_clk),
		.arst_n     (rst_sync_n),
		.in_bus     (rt_host_resp),
		.out_bus    (host_resp)
	);

	aos_softreg_router router_i (
		.global_clk (global_clk),
		.arst_n     (rst_sync_n),
		.host_req   (rt_host_req),
		.app_enable (app_enable),
		.app_req    (rt_app_req),
		.app_resp   (rt_app_resp),
		.host_resp  (rt_host_resp),
		.busy       (busy)
	);

	// ------------------------------------------------------------------
	// Application slots
	// ------------------------------------------------------------------
	for (genvar i = 0; i < `AOS_NUM_APPS; i++) begin : g_slot
		aos_sr_pipe #(
			.STAGES (`AOS_APP_PIPE_STAGES),
			.T      (aos_pkg::sr_req_t)
		) req_pipe_i (
			.global_clk (global_clk),
			.arst_n     (rst_sync_n),
			.in_bus     (rt_app_req[i]),
			.out_bus    (app_req[i])
		);

		aos_sr_pipe #(
			.STAGES (`AOS_APP_PIPE_STAGES),
			.T      (aos_pkg::sr_resp_t)
		) resp_pipe_i (
			.global_clk (global_clk),
			.arst_n     (rst_sync_n),
			.in_bus     (app_resp[i]),
			.out_bus    (rt_app_resp[i])
		);

		aos_demo_app app_i (
			.global_clk (global_clk),
			.arst_n     (rst_sync_n),
			.req        (app_req[i]),
			.resp       (app_resp[i])
		);
	end

endmodule

// ==== hw/aos_softreg_router.sv ====
/*
 * Soft-register router
 *   slot decode from the address, gated by per-slot enables
 *   one registered request stage toward the slots
 *   outstanding read tracking and busy flag
 *   response merge stage, dead-data answer for disabled slots
 */
`timescale 1ns/1ps
`include "aos_params.svh"

module aos_softreg_router (
	input  logic                       global_clk,
	input  logic                       arst_n,
	input  aos_pkg::sr_req_t           host_req,
	input  logic [`AOS_NUM_APPS-1:0]   app_enable,
	output aos_pkg::sr_req_t           app_req [`AOS_NUM_APPS],
	input  aos_pkg::sr_resp_t          app_resp [`AOS_NUM_APPS],
	output aos_pkg::sr_resp_t          host_resp,
	output logic                       busy
);

	logic [`AOS_APP_SEL_W-1:0] slot_sel;
	logic                      slot_en;
	logic                      is_read;
	logic                      enabled_rd;
	logic                      dead_rd;
	logic [`AOS_NUM_APPS-1:0]  slot_hit;

	logic [`AOS_NUM_APPS-1:0]  req_valid_q;
	aos_pkg::sr_op_e           req_op_q;
	logic [`AOS_ADDR_W-1:0]    req_addr_q;
	logic [`AOS_DATA_W-1:0]    req_data_q;

	aos_pkg::sr_resp_t         merge_d;
	logic                      merge_valid_q;
	logic [`AOS_DATA_W-1:0]    merge_data_q;

	aos_pkg::rt_state_e        state_q;
	aos_pkg::rt_state_e        state_d;

	// ------------------------------------------------------------------
	// Request decode
	// ------------------------------------------------------------------
	assign slot_sel   = host_req.addr[`AOS_APP_SEL_LSB +: `AOS_APP_SEL_W];
	assign slot_en    = app_enable[slot_sel];
	assign is_read    = host_req.valid && (host_req.op == aos_pkg::SR_READ);
	assign enabled_rd = is_read && slot_en;
	assign dead_rd    = is_read && !slot_en;

	// One-hot slot strobe, writes to disabled slots vanish here
	always_comb begin
		slot_hit = '0;
		slot_hit[slot_sel] = host_req.valid && slot_en;
	end

	always_ff @(posedge global_clk or negedge arst_n) begin
		if (!arst_n) begin
			req_valid_q <= '0;
		end else begin
			req_valid_q <= slot_hit;
		end
	end

	// Payload is shared by all slots
	always_ff @(posedge global_clk) begin
		if (host_req.valid) begin
			req_op_q   <= host_req.op;
			req_addr_q <= host_req.addr;
			req_data_q <= host_req.data;
		end
	end

	always_comb begin
		for (int i = 0; i < `AOS_NUM_APPS; i++) begin
			app_req[i].valid = req_valid_q[i];
			app_req[i].op    = req_op_q;
			app_req[i].addr  = req_addr_q;
			app_req[i].data  = req_data_q;
		end
	end

	// ------------------------------------------------------------------
	// Response merge
	// ------------------------------------------------------------------
	always_comb begin
		merge_d = '0;
		for (int i = 0; i < `AOS_NUM_APPS; i++) begin
			merge_d.valid = merge_d.valid | app_resp[i].valid;
			if (app_resp[i].valid) begin
				merge_d.data = merge_d.data | app_resp[i].data;
			end
		end
	end

	always_ff @(posedge global_clk or negedge arst_n) begin
		if (!arst_n) begin
			merge_valid_q <= 1'b0;
		end else begin
			merge_valid_q <= merge_d.valid;
		end
	end

	always_ff @(posedge global_clk) begin
		if (merge_d.valid) begin
			merge_data_q <= merge_d.data;
		end
	end

	// Disabled slot reads skip the slot path entirely
	always_comb begin
		if (dead_rd) begin
			host_resp.valid = 1'b1;
			host_resp.data  = `AOS_DEAD_DATA;
		end else begin
			host_resp.valid = merge_valid_q;
			host_resp.data  = merge_data_q;
		end
	end

	// ------------------------------------------------------------------
	// Outstanding read FSM
	// ------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			aos_pkg::RT_IDLE: begin
				if (enabled_rd) begin
					state_d = aos_pkg::RT_WAIT_READ;
				end
			end
			aos_pkg::RT_WAIT_READ: begin
				// Leave once the merge stage has shown the answer
				if (merge_valid_q) begin
					state_d = aos_pkg::RT_IDLE;
				end
			end
			default: state_d = aos_pkg::RT_IDLE;
		endcase
	end

	always_ff @(posedge global_clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= aos_pkg::RT_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign busy = (state_q == aos_pkg::RT_WAIT_READ);

endmodule

// ==== hw/aos_sr_pipe.sv ====
/*
 * Fixed-depth register pipeline for one soft-register bus
 *   STAGES  number of register stages
 *   T       request or response struct type
 */
`timescale 1ns/1ps

module aos_sr_pipe #(
	parameter int  STAGES = 2,
	parameter type T      = aos_pkg::sr_req_t
) (
	input  logic global_clk,
	input  logic arst_n,
	input  T     in_bus,
	output T     out_bus
);

	T stage_q [STAGES];

	// Every stage cleared so no stale valid leaves after reset
	always_ff @(posedge global_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= in_bus;
			for (int i = 1; i < STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign out_bus = stage_q[STAGES-1];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the soft-register shell testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module aos_tb \
	-f sources.f \
	-o aos_sim

./obj_dir/aos_sim

// ==== sources.f ====
+incdir+hw
hw/aos_pkg.sv
hw/aos_rst_sync.sv
hw/aos_sr_pipe.sv
hw/aos_softreg_router.sv
hw/aos_demo_app.sv
hw/aos_shell_top.sv
tb/aos_router_chk.sv
tb/aos_tb.sv

// ==== tb/aos_router_chk.sv ====
/*
 * Concurrent assertions on the soft-register router
 *   no host read reaches the router while busy
 *   every slot response answers a read sent to that slot
 *   no slot response while the router is idle
 */
`timescale 1ns/1ps
`include "aos_params.svh"

module aos_router_chk (
	input  logic                  global_clk,
	input  logic                  arst_n,
	input  aos_pkg::rt_state_e    state_q,
	input  logic                  busy,
	input  aos_pkg::sr_req_t      host_req,
	input  aos_pkg::sr_req_t      app_req [`AOS_NUM_APPS],
	input  aos_pkg::sr_resp_t     app_resp [`AOS_NUM_APPS]
);

	// Slot pipe, app register, slot pipe
	localparam int SLOT_RD_LAT = 2 * `AOS_APP_PIPE_STAGES + 1;

	logic [`AOS_NUM_APPS-1:0] rd_req_vec;
	logic [`AOS_NUM_APPS-1:0] resp_valid_vec;

	// Gather the per-slot read strobes and response valids into vectors
	always_comb begin
		for (int i = 0; i < `AOS_NUM_APPS; i++) begin
			rd_req_vec[i]     = app_req[i].valid && (app_req[i].op == aos_pkg::SR_READ);
			resp_valid_vec[i] = app_resp[i].valid;
		end
	end

	no_read_while_busy: assert property (@(posedge global_clk) disable iff (!arst_n)
		busy |-> !(host_req.valid && (host_req.op == aos_pkg::SR_READ)))
		else $error("read request reached the router while busy");

	resp_from_read_slot: assert property (@(posedge global_clk) disable iff (!arst_n)
		(resp_valid_vec != '0) |-> (resp_valid_vec == $past(rd_req_vec, SLOT_RD_LAT)))
		else $error("slot response does not match a read sent to that slot");

	no_resp_when_idle: assert property (@(posedge global_clk) disable iff (!arst_n)
		(state_q == aos_pkg::RT_IDLE) |-> (resp_valid_vec == '0))
		else $error("slot response arrived while no read was outstanding");

endmodule

// ==== tb/aos_tb.sv ====
/*
 * Directed testbench for the soft-register shell
 *   clock, reset, host read and write tasks, reference model
 *   tests for reset values, scratch registers, write count,
 *   disabled slots and read timing; watchdog and router checker
 */
`timescale 1ns/1ps
`include "aos_params.svh"

module aos_tb;

	localparam int CLK_PERIOD     = 8;
	// Host pipe, router, slot pipe, app, slot pipe, merge, host pipe
	localparam int ENABLED_RD_LAT = 2 * `AOS_HOST_PIPE_STAGES + 2 * `AOS_APP_PIPE_STAGES + 3;
	localparam int DEAD_RD_LAT    = 2 * `AOS_HOST_PIPE_STAGES;
	localparam int BUSY_RISE      = `AOS_HOST_PIPE_STAGES + 1;
	localparam int BUSY_LAST      = ENABLED_RD_LAT - `AOS_HOST_PIPE_STAGES;
	localparam int RD_TIMEOUT     = 4 * ENABLED_RD_LAT;
	// Reads and writes issued by all five tests
	localparam int RESET_CYCLES   = 8;
	localparam int NUM_READS      = 49;
	localparam int NUM_WRITES     = 28;
	localparam int TEST_CYCLES    = RESET_CYCLES + NUM_READS * (ENABLED_RD_LAT + 1) + NUM_WRITES;
	localparam int WATCHDOG_NS    = 20 * TEST_CYCLES * CLK_PERIOD;

	logic                     global_clk = 1'b0;
	logic                     arst_n;
	aos_pkg::sr_req_t         host_req;
	logic [`AOS_NUM_APPS-1:0] app_enable;
	aos_pkg::sr_resp_t        host_resp;
	logic                     busy;

	logic [31:0]              rng_state = 32'ha787_9246;
	logic [`AOS_DATA_W-1:0]   scratch_model [`AOS_NUM_APPS][3];
	logic [`AOS_DATA_W-1:0]   count_model [`AOS_NUM_APPS];

	always #(CLK_PERIOD / 2) global_clk = ~global_clk;

	aos_shell_top dut_i (
		.global_clk (global_clk),
		.arst_n     (arst_n),
		.host_req   (host_req),
		.app_enable (app_enable),
		.host_resp  (host_resp),
		.busy       (busy)
	);

	bind aos_softreg_router aos_router_chk router_chk_i (
		.global_clk (global_clk),
		.arst_n     (arst_n),
		.state_q    (state_q),
		.busy       (busy),
		.host_req   (host_req),
		.app_req    (app_req),
		.app_resp   (app_resp)
	);

	// ------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x_in);
		logic [31:0] x;
		x = x_in;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [`AOS_ADDR_W-1:0] reg_addr(input int slot, input int rg);
		return (32'(slot) << `AOS_APP_SEL_LSB) | (32'(rg) << `AOS_REG_SEL_LSB);
	endfunction

	task automatic rand_data(output logic [`AOS_DATA_W-1:0] d);
		rng_state = xorshift32(rng_state);
		d[63:32] = rng_state;
		rng_state = xorshift32(rng_state);
		d[31:0] = rng_state;
	endtask

	task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
				$time, msg, actual, expected);
			$display("Some tests failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// Called at 1 ns after an edge, returns at 1 ns after the next one
	task automatic sr_write(input int slot, input int rg, input logic [`AOS_DATA_W-1:0] data);
		host_req.valid = 1'b1;
		host_req.op    = aos_pkg::SR_WRITE;
		host_req.addr  = reg_addr(slot, rg);
		host_req.data  = data;
		@(posedge global_clk);
		#1;
		host_req.valid = 1'b0;
	endtask

	// Writes to a disabled slot are dropped, every accepted write counts
	task automatic write_tracked(input int slot, input int rg,
			input logic [`AOS_DATA_W-1:0] data);
		if (app_enable[slot]) begin
			if (rg < 3) begin
				scratch_model[slot][rg] = data;
			end
			count_model[slot] = count_model[slot] + 64'd1;
		end
		sr_write(slot, rg, data);
	endtask

	task automatic sr_read(input int slot, input int rg, output logic [`AOS_DATA_W-1:0] data,
			output int lat, output logic [31:0] busy_seen);
		int   k;
		logic got;
		check_eq(64'(busy), 64'd0, "read issued while busy");
		busy_seen      = '0;
		got            = 1'b0;
		k              = 0;
		host_req.valid = 1'b1;
		host_req.op    = aos_pkg::SR_READ;
		host_req.addr  = reg_addr(slot, rg);
		host_req.data  = '0;
		while (!got) begin
			@(posedge global_clk);
			#1;
			host_req.valid = 1'b0;
			k++;
			if (k < 32) begin
				busy_seen[k] = busy;
			end
			if (host_resp.valid) begin
				got = 1'b1;
			end else if (k >= RD_TIMEOUT) begin
				$display("No read response from slot %0d reg %0d after %0d cycles",
					slot, rg, k);
				$display("Some tests failed");
				$fatal(1, "read response timeout");
			end
		end
		data = host_resp.data;
		lat  = k;
	endtask

	task automatic read_check(input int slot, input int rg, input logic [63:0] exp_data,
			input int exp_lat, input string what);
		logic [`AOS_DATA_W-1:0] data;
		int                     lat;
		logic [31:0]            busy_seen;
		sr_read(slot, rg, data, lat, busy_seen);
		check_eq(data, exp_data, $sformatf("%s: slot %0d reg %0d data", what, slot, rg));
		check_eq(64'(lat), 64'(exp_lat),
			$sformatf("%s: slot %0d reg %0d latency", what, slot, rg));
	endtask

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------
	task automatic test_reset_values();
		check_eq(64'(busy), 64'd0, "busy after reset");
		check_eq(64'(host_resp.valid), 64'd0, "response valid after reset");
		for (int s = 0; s < `AOS_NUM_APPS; s++) begin
			for (int r = 0; r < 4; r++) begin
				read_check(s, r, 64'd0, ENABLED_RD_LAT, "reset value");
			end
		end
	endtask

	task automatic test_scratch_rw();
		logic [`AOS_DATA_W-1:0] d;
		// Back to back, no gap between writes
		for (int s = 0; s < `AOS_NUM_APPS; s++) begin
			for (int r = 0; r < 3; r++) begin
				rand_data(d);
				write_tracked(s, r, d);
			end
		end
		for (int s = 0; s < `AOS_NUM_APPS; s++) begin
			for (int r = 0; r < 3; r++) begin
				read_check(s, r, scratch_model[s][r], ENABLED_RD_LAT, "scratch");
			end
		end
	endtask

	task automatic test_write_count();
		logic [`AOS_DATA_W-1:0] d;
		for (int s = 0; s < `AOS_NUM_APPS; s++) begin
			read_check(s, 3, count_model[s], ENABLED_RD_LAT, "count before");
			rand_data(d);
			write_tracked(s, 3, d);
			write_tracked(s, 3, ~d);
			write_tracked(s, 1, d);
			read_check(s, 3, count_model[s], ENABLED_RD_LAT, "count after");
			read_check(s, 1, scratch_model[s][1], ENABLED_RD_LAT, "scratch next to count");
		end
	endtask

	task automatic test_disabled_slot();
		logic [`AOS_DATA_W-1:0] d;
		app_enable[2] = 1'b0;
		read_check(2, 0, `AOS_DEAD_DATA, DEAD_RD_LAT, "disabled");
		for (int r = 0; r < 3; r++) begin
			rand_data(d);
			write_tracked(2, r, d);
		end
		rand_data(d);
		write_tracked(1, 0, d);
		// Dead read trails the dropped writes through the host pipe
		read_check(2, 1, `AOS_DEAD_DATA, DEAD_RD_LAT, "disabled");
		app_enable[2] = 1'b1;
		for (int r = 0; r < 3; r++) begin
			read_check(2, r, scratch_model[2][r], ENABLED_RD_LAT, "re-enabled scratch");
		end
		read_check(2, 3, count_model[2], ENABLED_RD_LAT, "re-enabled count");
		read_check(1, 0, scratch_model[1][0], ENABLED_RD_LAT, "neighbour of disabled slot");
	endtask

	task automatic test_read_timing();
		logic [`AOS_DATA_W-1:0] data;
		int                     lat;
		logic [31:0]            busy_seen;
		logic                   exp_busy;
		sr_read(0, 0, data, lat, busy_seen);
		check_eq(data, scratch_model[0][0], "timed read data");
		check_eq(64'(lat), 64'(ENABLED_RD_LAT), "enabled read latency");
		for (int k = 1; k <= ENABLED_RD_LAT; k++) begin
			exp_busy = (k >= BUSY_RISE) && (k <= BUSY_LAST);
			check_eq(64'(busy_seen[k]), 64'(exp_busy),
				$sformatf("busy %0d cycles after read", k));
		end
		app_enable[3] = 1'b0;
		read_check(3, 0, `AOS_DEAD_DATA, DEAD_RD_LAT, "timed dead read");
		app_enable[3] = 1'b1;
	endtask

	// ------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------
	initial begin
		arst_n     = 1'b0;
		host_req   = '0;
		app_enable = '1;
		for (int s = 0; s < `AOS_NUM_APPS; s++) begin
			for (int r = 0; r < 3; r++) begin
				scratch_model[s][r] = '0;
			end
			count_model[s] = '0;
		end
		repeat (4) @(posedge global_clk);
		#1;
		arst_n = 1'b1;
		// Let the synchronized reset release
		repeat (4) @(posedge global_clk);
		#1;
		test_reset_values();
		test_scratch_rw();
		test_write_count();
		test_disabled_slot();
		test_read_timing();
		$display("All tests passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule
